// ==== exc_params.svh ====
`ifndef EXC_PARAMS_SVH
`define EXC_PARAMS_SVH

// csr addresses
`define CSR_ADDR_W     14
`define CSR_CRMD       14'h000
`define CSR_PRMD       14'h001
`define CSR_ECFG       14'h004
`define CSR_ESTAT      14'h005
`define CSR_ERA        14'h006
`define CSR_BADV       14'h007
`define CSR_EENTRY     14'h00c

// cause codes, {esubcode bit, ecode}
`define ECODE_W        7
`define EXCEPTION_INT  7'h00
`define EXCEPTION_NOP  7'h7f

// widths
`define EXC_SRC_W      6
`define PAUSE_W        7
`define INT_W          12
`define HW_INT_W       8

`endif

// ==== pipeline_types_pkg.sv ====
`include "exc_params.svh"

package pipeline_types_pkg;

    typedef logic [31:0] bus32_t;

    typedef struct packed {
        logic pause_if;
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_t;

    typedef struct packed {
        logic                                   valid;
        bus32_t                                 pc;
        logic [`EXC_SRC_W-1:0]                  is_exception;
        logic [`EXC_SRC_W-1:0][`ECODE_W-1:0]    exception_cause;
        bus32_t                                 exception_addr;
        logic                                   is_ertn;
        logic                                   is_idle;
    } mem_ctrl_t;

    typedef struct packed {
        logic                   csr_write_en;
        logic [`CSR_ADDR_W-1:0] csr_write_addr;
        bus32_t                 csr_write_data;
    } wb_push_forward_t;

    // one csr data word, seen as crmd/prmd or as lie/is
    typedef union packed {
        struct packed {
            logic [28:0] rsvd;
            logic        ie;
            logic [1:0]  plv;
        } mode;
        struct packed {
            logic [18:0] rsvd_hi;
            logic [1:0]  lie_hi;
            logic        rsvd_lo;
            logic [9:0]  lie_lo;
        } intr;
    } csr_word_u;

    typedef struct packed {
        bus32_t             era_pc;
        bus32_t             eentry_va;
        logic [`INT_W-1:0]  ecfg_lie;
        logic [`INT_W-1:0]  estat_is;
        logic               crmd_ie;
    } ctrl_csr_t;

    typedef struct packed {
        logic                is_exception;
        logic                is_ertn;
        logic [`ECODE_W-1:0] exception_cause;
        bus32_t              exception_pc;
        bus32_t              exception_addr;
        logic                ecode_int;
    } csr_exc_t;

    typedef struct packed {
        logic                exception_flush;
        logic [`PAUSE_W-1:0] pause;
    } ctrl_t;

    typedef struct packed {
        bus32_t exception_new_pc;
        logic   is_interrupt;
        logic   redirect_en;
    } ctrl_pc_t;

endpackage

// ==== csr_exc_regs.sv ====
`timescale 1ns/100ps
`include "exc_params.svh"

module csr_exc_regs
    import pipeline_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  wb_push_forward_t       wb_i,
    input  csr_exc_t               exc_i,
    input  logic [`HW_INT_W-1:0]   hw_int_i,
    input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    output ctrl_csr_t              csr_o,
    output bus32_t                 csr_rdata_o
);

    logic                 crmd_ie;
    logic                 prmd_pie;
    logic [`INT_W-1:0]    ecfg_lie;
    logic [1:0]           estat_sw;
    logic [`HW_INT_W-1:0] estat_hw;
    logic [`ECODE_W-1:0]  estat_ecode;
    bus32_t               era;
    bus32_t               eentry;
    bus32_t               badv;

    csr_word_u wdata;
    logic      wr_crmd;
    logic      wr_prmd;
    logic      wr_ecfg;
    logic      wr_estat;
    logic      wr_era;
    logic      wr_eentry;
    logic      wr_badv;
    logic      ie_now;
    logic      pie_now;

    // ====================
    // write decode
    // ====================
    assign wdata     = wb_i.csr_write_data;
    assign wr_crmd   = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_CRMD);
    assign wr_prmd   = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_PRMD);
    assign wr_ecfg   = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_ECFG);
    assign wr_estat  = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_ESTAT);
    assign wr_era    = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_ERA);
    assign wr_eentry = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_EENTRY);
    assign wr_badv   = wb_i.csr_write_en && (wb_i.csr_write_addr == `CSR_BADV);

    // ie and pie as they stand after this cycle's write
    assign ie_now  = wr_crmd ? wdata.mode.ie : crmd_ie;
    assign pie_now = wr_prmd ? wdata.mode.ie : prmd_pie;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd_ie     <= 1'b0;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_sw    <= '0;
            estat_hw    <= '0;
            estat_ecode <= '0;
            era         <= '0;
            eentry      <= '0;
            badv        <= '0;
        end else begin
            estat_hw <= hw_int_i;
            if (wr_crmd) begin
                crmd_ie <= wdata.mode.ie;
            end
            if (wr_prmd) begin
                prmd_pie <= wdata.mode.ie;
            end
            // timer bit 11 not implemented
            if (wr_ecfg) begin
                ecfg_lie <= {wdata.intr.lie_hi[1], 1'b0, wdata.intr.lie_lo};
            end
            if (wr_estat) begin
                estat_sw <= wdata.intr.lie_lo[1:0];
            end
            if (wr_era) begin
                era <= wb_i.csr_write_data;
            end
            if (wr_eentry) begin
                eentry <= wb_i.csr_write_data;
            end
            if (wr_badv) begin
                badv <= wb_i.csr_write_data;
            end
            // trap updates override the writeback
            if (exc_i.is_exception) begin
                era         <= exc_i.exception_pc;
                badv        <= exc_i.exception_addr;
                estat_ecode <= exc_i.ecode_int ? `EXCEPTION_INT : exc_i.exception_cause;
                prmd_pie    <= ie_now;
                crmd_ie     <= 1'b0;
            end else if (exc_i.is_ertn) begin
                crmd_ie <= pie_now;
            end
        end
    end

    assign csr_o = '{
        era_pc:    era,
        eentry_va: eentry,
        ecfg_lie:  ecfg_lie,
        estat_is:  {2'b00, estat_hw, estat_sw},
        crmd_ie:   crmd_ie
    };

    // ====================
    // read port
    // ====================
    always_comb begin
        case (csr_raddr_i)
            `CSR_CRMD:   csr_rdata_o = {29'b0, crmd_ie, 2'b0};
            `CSR_PRMD:   csr_rdata_o = {29'b0, prmd_pie, 2'b0};
            `CSR_ECFG:   csr_rdata_o = {19'b0, ecfg_lie[11:10], 1'b0, ecfg_lie[9:0]};
            // ecode in 21:16, top cause bit as esubcode bit 22
            `CSR_ESTAT:  csr_rdata_o = {9'b0, estat_ecode, 6'b0, estat_hw, estat_sw};
            `CSR_ERA:    csr_rdata_o = era;
            `CSR_EENTRY: csr_rdata_o = eentry;
            `CSR_BADV:   csr_rdata_o = badv;
            default:     csr_rdata_o = '0;
        endcase
    end

    // ctrl never raises both in one cycle
    a_exc_ertn_excl: assert property (
        @(posedge clk) disable iff (rst_i) !(exc_i.is_exception && exc_i.is_ertn)
    );

endmodule

// ==== ctrl.sv ====
`timescale 1ns/100ps
`include "exc_params.svh"

module ctrl
    import pipeline_types_pkg::*;
(
    input  pause_t           pause_request_i,
    input  mem_ctrl_t        mem_i,
    input  wb_push_forward_t wb_push_forward_i,
    input  logic             continue_idle_i,
    input  ctrl_csr_t        csr_i,
    output csr_exc_t         csr_exc_o,
    output ctrl_t            ctrl_o,
    output ctrl_pc_t         ctrl_pc_o,
    output logic             send_inst1_en_o
);

    csr_word_u           wdata;
    logic                wr_hit_era;
    logic                wr_hit_eentry;
    logic                wr_hit_ecfg;
    logic                wr_hit_estat;
    logic                wr_hit_crmd;
    bus32_t              era_cur;
    bus32_t              eentry_cur;
    logic [`INT_W-1:0]   lie_cur;
    logic [`INT_W-1:0]   is_cur;
    logic                ie_cur;
    logic [`INT_W-1:0]   int_vec;
    logic                is_interrupt;
    logic [`ECODE_W-1:0] src_cause;
    logic                exc_taken;
    logic                ertn_taken;
    logic                pause_idle;
    logic [`PAUSE_W-1:0] pause_mask;

    // ====================
    // writeback forwarding
    // ====================
    assign wdata = wb_push_forward_i.csr_write_data;

    assign wr_hit_era    = wb_push_forward_i.csr_write_en &&
                           (wb_push_forward_i.csr_write_addr == `CSR_ERA);
    assign wr_hit_eentry = wb_push_forward_i.csr_write_en &&
                           (wb_push_forward_i.csr_write_addr == `CSR_EENTRY);
    assign wr_hit_ecfg   = wb_push_forward_i.csr_write_en &&
                           (wb_push_forward_i.csr_write_addr == `CSR_ECFG);
    assign wr_hit_estat  = wb_push_forward_i.csr_write_en &&
                           (wb_push_forward_i.csr_write_addr == `CSR_ESTAT);
    assign wr_hit_crmd   = wb_push_forward_i.csr_write_en &&
                           (wb_push_forward_i.csr_write_addr == `CSR_CRMD);

    assign era_cur    = wr_hit_era ? wb_push_forward_i.csr_write_data : csr_i.era_pc;
    assign eentry_cur = wr_hit_eentry ? wb_push_forward_i.csr_write_data : csr_i.eentry_va;
    assign lie_cur    = wr_hit_ecfg ? {wdata.intr.lie_hi[1], 1'b0, wdata.intr.lie_lo}
                                    : csr_i.ecfg_lie;
    // only the software bits are writable
    assign is_cur     = wr_hit_estat ? {csr_i.estat_is[`INT_W-1:2], wdata.intr.lie_lo[1:0]}
                                     : csr_i.estat_is;
    assign ie_cur     = wr_hit_crmd ? wdata.mode.ie : csr_i.crmd_ie;

    // ====================
    // interrupt and exception
    // ====================
    assign int_vec      = ie_cur ? (lie_cur & is_cur) : '0;
    assign is_interrupt = |int_vec;

    // highest index wins
    always_comb begin
        src_cause = `EXCEPTION_NOP;
        for (int i = 0; i < `EXC_SRC_W; i++) begin
            if (mem_i.is_exception[i]) begin
                src_cause = mem_i.exception_cause[i];
            end
        end
    end

    assign exc_taken  = mem_i.valid && (is_interrupt || (|mem_i.is_exception));
    assign ertn_taken = mem_i.valid && mem_i.is_ertn && !exc_taken;

    assign csr_exc_o = '{
        is_exception:    exc_taken,
        is_ertn:         ertn_taken,
        exception_cause: !exc_taken ? `EXCEPTION_NOP
                         : (is_interrupt ? `EXCEPTION_INT : src_cause),
        exception_pc:    mem_i.pc,
        exception_addr:  mem_i.exception_addr,
        ecode_int:       exc_taken && is_interrupt
    };

    assign ctrl_pc_o = '{
        exception_new_pc: ertn_taken ? era_cur : eentry_cur,
        is_interrupt:     is_interrupt,
        redirect_en:      exc_taken || ertn_taken
    };

    // ====================
    // pause mask
    // ====================
    assign pause_idle = mem_i.valid && mem_i.is_idle && !is_interrupt && !continue_idle_i;

    // bit order: pc, ibuf, id, dispatch, ex, mem, wb
    always_comb begin
        if (pause_request_i.pause_if) begin
            pause_mask = 7'b0000001;
        end else if (pause_request_i.pause_id) begin
            pause_mask = 7'b0000111;
        end else if (pause_request_i.pause_dispatch) begin
            pause_mask = 7'b0001111;
        end else if (pause_request_i.pause_ex) begin
            pause_mask = 7'b0011111;
        end else if (pause_request_i.pause_mem || pause_idle) begin
            pause_mask = 7'b0111111;
        end else begin
            pause_mask = '0;
        end
    end

    assign ctrl_o = '{exception_flush: exc_taken || ertn_taken, pause: pause_mask};

    assign send_inst1_en_o = !pause_mask[1];

endmodule

// ==== exc_unit_top.sv ====
`timescale 1ns/100ps
`include "exc_params.svh"

module exc_unit_top
    import pipeline_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  pause_t                 pause_request_i,
    input  mem_ctrl_t              mem_i,
    input  wb_push_forward_t       wb_push_forward_i,
    input  logic                   continue_idle_i,
    input  logic [`HW_INT_W-1:0]   hw_int_i,
    input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    output ctrl_t                  ctrl_o,
    output ctrl_pc_t               ctrl_pc_o,
    output logic                   send_inst1_en_o,
    output bus32_t                 csr_rdata_o
);

    ctrl_csr_t csr_view;
    csr_exc_t  exc_rec;

    ctrl ctrl_i (
        .pause_request_i   (pause_request_i),
        .mem_i             (mem_i),
        .wb_push_forward_i (wb_push_forward_i),
        .continue_idle_i   (continue_idle_i),
        .csr_i             (csr_view),
        .csr_exc_o         (exc_rec),
        .ctrl_o            (ctrl_o),
        .ctrl_pc_o         (ctrl_pc_o),
        .send_inst1_en_o   (send_inst1_en_o)
    );

    csr_exc_regs csr_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_i        (wb_push_forward_i),
        .exc_i       (exc_rec),
        .hw_int_i    (hw_int_i),
        .csr_raddr_i (csr_raddr_i),
        .csr_o       (csr_view),
        .csr_rdata_o (csr_rdata_o)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== exc_unit_tb.sv ====
`timescale 1ns/100ps
`include "exc_params.svh"

module exc_unit_tb
    import pipeline_types_pkg::*;
();

    localparam int N_EXC       = 30;
    localparam int N_RAND      = 1200;
    localparam int TEST_CYCLES = 5 + 32 + 1 + N_EXC * 6 + 10 + 12 + 20 + N_RAND + 2;
    localparam int MAX_CYCLES  = TEST_CYCLES + TEST_CYCLES / 4;

    typedef struct packed {
        ctrl_t    c;
        ctrl_pc_t p;
        logic     s;
    } exp_t;

    logic                   clk;
    logic                   rst;
    pause_t                 pause_req;
    mem_ctrl_t              mem;
    wb_push_forward_t       wb;
    logic                   cont_idle;
    logic [`HW_INT_W-1:0]   hw_int;
    logic [`CSR_ADDR_W-1:0] raddr;
    ctrl_t                  dut_ctrl;
    ctrl_pc_t               dut_pc;
    logic                   dut_send1;
    bus32_t                 dut_rdata;

    // csr model
    logic                 m_ie;
    logic                 m_pie;
    bus32_t               m_ecfg;
    logic [1:0]           m_sw;
    logic [`HW_INT_W-1:0] m_hw;
    logic [`ECODE_W-1:0]  m_ecode;
    bus32_t               m_era;
    bus32_t               m_eentry;
    bus32_t               m_badv;

    integer seed = 54361;
    int     cycles = 0;
    int     fail_count = 0;
    string  test_name = "reset";

    logic [`CSR_ADDR_W-1:0] csr_addrs [8] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT,
                                              `CSR_ERA, `CSR_EENTRY, `CSR_BADV, 14'h003};

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

    exc_unit_top dut_i (
        .clk               (clk),
        .rst_i             (rst),
        .pause_request_i   (pause_req),
        .mem_i             (mem),
        .wb_push_forward_i (wb),
        .continue_idle_i   (cont_idle),
        .hw_int_i          (hw_int),
        .csr_raddr_i       (raddr),
        .ctrl_o            (dut_ctrl),
        .ctrl_pc_o         (dut_pc),
        .send_inst1_en_o   (dut_send1),
        .csr_rdata_o       (dut_rdata)
    );

    // ====================
    // reference model
    // ====================
    function automatic logic wr_hit(wb_push_forward_t w, logic [`CSR_ADDR_W-1:0] a);
        return w.csr_write_en && (w.csr_write_addr == a);
    endfunction

    // ecfg bits 11:10 read zero, so only lines 9:0 can fire
    function automatic logic [9:0] int_vector(wb_push_forward_t w);
        bus32_t     ecfg_f;
        logic [9:0] is_f;
        logic       ie_f;
        ecfg_f = wr_hit(w, `CSR_ECFG) ? (w.csr_write_data & 32'h13ff) : m_ecfg;
        is_f   = {m_hw, wr_hit(w, `CSR_ESTAT) ? w.csr_write_data[1:0] : m_sw};
        ie_f   = wr_hit(w, `CSR_CRMD) ? w.csr_write_data[2] : m_ie;
        return ie_f ? (ecfg_f[9:0] & is_f) : 10'b0;
    endfunction

    function automatic logic [`ECODE_W-1:0] top_cause(mem_ctrl_t m);
        for (int i = `EXC_SRC_W - 1; i >= 0; i--) begin
            if (m.is_exception[i]) begin
                return m.exception_cause[i];
            end
        end
        return `EXCEPTION_NOP;
    endfunction

    function automatic exp_t predict(pause_t p, mem_ctrl_t m, wb_push_forward_t w, logic cont);
        exp_t e;
        logic intr;
        logic exc;
        logic ertn;
        logic idle;
        int   n;
        intr = |int_vector(w);
        exc  = m.valid && (intr || (m.is_exception != '0));
        ertn = m.valid && m.is_ertn && !exc;
        idle = m.valid && m.is_idle && !intr && !cont;
        if (p.pause_if) n = 1;
        else if (p.pause_id) n = 3;
        else if (p.pause_dispatch) n = 4;
        else if (p.pause_ex) n = 5;
        else if (p.pause_mem || idle) n = 6;
        else n = 0;
        e.c.exception_flush = exc || ertn;
        e.c.pause = 7'((1 << n) - 1);
        if (ertn) begin
            e.p.exception_new_pc = wr_hit(w, `CSR_ERA) ? w.csr_write_data : m_era;
        end else begin
            e.p.exception_new_pc = wr_hit(w, `CSR_EENTRY) ? w.csr_write_data : m_eentry;
        end
        e.p.is_interrupt = intr;
        e.p.redirect_en  = exc || ertn;
        e.s = !e.c.pause[1];
        return e;
    endfunction

    function automatic bus32_t read_csr(logic [`CSR_ADDR_W-1:0] a);
        case (a)
            `CSR_CRMD:   return {29'b0, m_ie, 2'b0};
            `CSR_PRMD:   return {29'b0, m_pie, 2'b0};
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return {9'b0, m_ecode, 6'b0, m_hw, m_sw};
            `CSR_ERA:    return m_era;
            `CSR_EENTRY: return m_eentry;
            `CSR_BADV:   return m_badv;
            default:     return 32'b0;
        endcase
    endfunction

    // state after the coming rising edge
    task automatic update_model();
        logic   intr;
        logic   exc;
        logic   ertn;
        logic   ie_w;
        logic   pie_w;
        bus32_t d;
        if (rst) begin
            {m_ie, m_pie, m_sw, m_hw, m_ecode} = '0;
            {m_ecfg, m_era, m_eentry, m_badv} = '0;
        end else begin
            d     = wb.csr_write_data;
            intr  = |int_vector(wb);
            exc   = mem.valid && (intr || (mem.is_exception != '0));
            ertn  = mem.valid && mem.is_ertn && !exc;
            ie_w  = wr_hit(wb, `CSR_CRMD) ? d[2] : m_ie;
            pie_w = wr_hit(wb, `CSR_PRMD) ? d[2] : m_pie;
            m_hw  = hw_int;
            m_ie  = ie_w;
            m_pie = pie_w;
            if (wr_hit(wb, `CSR_ECFG)) m_ecfg = d & 32'h13ff;
            if (wr_hit(wb, `CSR_ESTAT)) m_sw = d[1:0];
            if (wr_hit(wb, `CSR_ERA)) m_era = d;
            if (wr_hit(wb, `CSR_EENTRY)) m_eentry = d;
            if (wr_hit(wb, `CSR_BADV)) m_badv = d;
            if (exc) begin
                m_era   = mem.pc;
                m_badv  = mem.exception_addr;
                m_ecode = intr ? `EXCEPTION_INT : top_cause(mem);
                m_pie   = ie_w;
                m_ie    = 1'b0;
            end else if (ertn) begin
                m_ie = pie_w;
            end
        end
    endtask

    task automatic report_mismatch(string sig, logic [63:0] exp_v, logic [63:0] got_v);
        fail_count++;
        $display("[FAIL] %s %s expected %h actual %h", test_name, sig, exp_v, got_v);
        $display("Test FAILED");
        $fatal(1, "output mismatch");
    endtask

    // ====================
    // compare and timeout
    // ====================
    always @(negedge clk) begin : compare
        exp_t   e;
        bus32_t exp_rd;
        if (!rst) begin
            e      = predict(pause_req, mem, wb, cont_idle);
            exp_rd = read_csr(raddr);
            assert (dut_ctrl === e.c)
                else report_mismatch("ctrl_o", 64'(e.c), 64'(dut_ctrl));
            assert (dut_pc === e.p)
                else report_mismatch("ctrl_pc_o", 64'(e.p), 64'(dut_pc));
            assert (dut_send1 === e.s)
                else report_mismatch("send_inst1_en_o", 64'(e.s), 64'(dut_send1));
            assert (dut_rdata === exp_rd)
                else report_mismatch("csr_rdata_o", 64'(exp_rd), 64'(dut_rdata));
        end
        update_model();
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // ====================
    // stimulus helpers
    // ====================
    task automatic quiet();
        pause_req <= '0;
        mem       <= '0;
        wb        <= '0;
        cont_idle <= 1'b0;
    endtask

    function automatic wb_push_forward_t make_wb(logic [`CSR_ADDR_W-1:0] a, bus32_t d);
        return '{csr_write_en: 1'b1, csr_write_addr: a, csr_write_data: d};
    endfunction

    function automatic mem_ctrl_t make_plain();
        mem_ctrl_t m;
        m = '0;
        m.valid = 1'b1;
        m.pc = $random(seed);
        m.exception_addr = $random(seed);
        for (int k = 0; k < `EXC_SRC_W; k++) begin
            m.exception_cause[k] = 7'($random(seed));
        end
        return m;
    endfunction

    function automatic mem_ctrl_t make_exc(logic [`EXC_SRC_W-1:0] srcs);
        mem_ctrl_t m;
        m = make_plain();
        m.is_exception = srcs;
        return m;
    endfunction

    task automatic set_csr(logic [`CSR_ADDR_W-1:0] a, bus32_t d);
        @(posedge clk);
        quiet();
        wb <= make_wb(a, d);
    endtask

    task automatic read_back(logic [`CSR_ADDR_W-1:0] a);
        @(posedge clk);
        quiet();
        raddr <= a;
    endtask

    task automatic step_mem(mem_ctrl_t m);
        @(posedge clk);
        quiet();
        mem <= m;
    endtask

    initial begin : stimulus
        mem_ctrl_t             m;
        logic [`EXC_SRC_W-1:0] srcs;
        quiet();
        hw_int <= '0;
        raddr  <= '0;
        wait (rst == 1'b0);

        test_name = "pause_priority";
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            quiet();
            pause_req <= pause_t'(i[4:0]);
        end

        test_name = "exception_priority";
        set_csr(`CSR_EENTRY, 32'h1c00_8000);
        for (int i = 0; i < N_EXC; i++) begin
            set_csr(`CSR_CRMD, 32'h4);
            srcs = 6'($random(seed));
            if (srcs == '0) srcs = 6'h20;
            step_mem(make_exc(srcs));
            read_back(`CSR_ERA);
            read_back(`CSR_BADV);
            read_back(`CSR_ESTAT);
            read_back(`CSR_CRMD);
        end

        test_name = "ertn";
        for (int i = 0; i < 2; i++) begin
            set_csr(`CSR_CRMD, i == 0 ? 32'h4 : 32'h0);
            step_mem(make_exc(6'h01));
            m = make_plain();
            m.is_ertn = 1'b1;
            step_mem(m);
            read_back(`CSR_CRMD);
            read_back(`CSR_PRMD);
        end

        test_name = "forwarding";
        step_mem(make_exc(6'h04));
        wb <= make_wb(`CSR_EENTRY, 32'h1c00_9000);
        m = make_plain();
        m.is_ertn = 1'b1;
        step_mem(m);
        wb <= make_wb(`CSR_ERA, 32'h1c00_0abc);
        set_csr(`CSR_ECFG, 32'h0000_03ff);
        set_csr(`CSR_CRMD, 32'h0);
        hw_int <= 8'h02;
        step_mem(make_plain());
        wb <= make_wb(`CSR_CRMD, 32'h4);
        hw_int <= 8'h00;
        set_csr(`CSR_CRMD, 32'h4);
        step_mem(make_plain());
        wb <= make_wb(`CSR_ESTAT, 32'h1);
        set_csr(`CSR_ESTAT, 32'h0);

        test_name = "interrupt_idle";
        set_csr(`CSR_ECFG, 32'h0000_03fc);
        set_csr(`CSR_CRMD, 32'h4);
        m = make_plain();
        m.is_idle = 1'b1;
        repeat (4) step_mem(m);
        step_mem(m);
        cont_idle <= 1'b1;
        repeat (2) step_mem(m);
        hw_int <= 8'h10;
        repeat (3) step_mem(m);
        read_back(`CSR_ESTAT);
        set_csr(`CSR_CRMD, 32'h4);
        read_back(`CSR_CRMD);
        hw_int <= 8'h00;
        read_back(`CSR_CRMD);

        test_name = "random";
        for (int i = 0; i < N_RAND; i++) begin
            @(posedge clk);
            quiet();
            if (($random(seed) & 3) == 0) pause_req <= pause_t'($random(seed));
            m = make_plain();
            m.valid = 1'($random(seed));
            if (($random(seed) & 7) == 0) m.is_exception = 6'($random(seed));
            m.is_ertn = (($random(seed) & 7) == 0);
            m.is_idle = (($random(seed) & 7) == 0);
            mem <= m;
            if (($random(seed) & 1) == 1) begin
                wb <= make_wb(csr_addrs[3'($random(seed))], $random(seed));
            end
            if (($random(seed) & 15) == 0) hw_int <= 8'($random(seed));
            cont_idle <= (($random(seed) & 3) == 0);
            raddr <= csr_addrs[3'($random(seed))];
        end

        repeat (2) @(posedge clk);
        if (fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== exc_ctrl.f ====
+incdir+.
pipeline_types_pkg.sv
csr_exc_regs.sv
ctrl.sv
exc_unit_top.sv
tb_clk_gen.sv
exc_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exc_unit_tb
FILELIST  ?= exc_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
